// ==== spi_fabric.f ====
hdl/spi_fabric_pkg.sv
hdl/spi_reg_bank.sv
hdl/cs_router.sv
hdl/miso_router.sv
hdl/heartbeat.sv
hdl/spi_fabric_top.sv
testbench/spi_fabric_properties.sv
testbench/tb_spi_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the spi_fabric testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_spi_fabric \
  -f spi_fabric.f \
  -o sim_spi_fabric

# let every failing assertion print instead of stopping at the first
output=$(./obj_dir/sim_spi_fabric +verilator+error+limit+1000)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
  exit 0
else
  echo "run_sim.sh: pass message not found"
  exit 1
fi

// ==== testbench/tb_spi_fabric.sv ====
`timescale 1ns/1ps

module tb_spi_fabric
  import spi_fabric_pkg::*;
();

  localparam int num_periph = 3;
  localparam int log2_delay = 4;
  // spi half period in clk cycles
  localparam int half_cyc = 4;
  localparam int wait_limit = 64;
  // worst gap between two heartbeat led changes
  localparam int hb_limit = 2 ** (log2_delay + 1);

  logic                  clk;
  logic                  rst_n;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  special_n;
  logic                  miso;
  logic                  periph_sclk;
  logic                  periph_mosi;
  logic [num_periph-1:0] periph_cs_n;
  logic [num_periph-1:0] periph_miso;
  logic [7:0]            led;
  logic [3:0]            dac_ctrl;
  logic [1:0]            hb_led;

  // register model
  logic [7:0] exp_led;
  logic [7:0] exp_mux;
  logic [3:0] exp_dac;

  int mismatch_cnt;
  int timeout_cnt;

  spi_fabric_top #(
    .num_periph (num_periph),
    .log2_delay (log2_delay)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .miso        (miso),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .hb_led      (hb_led)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks and models
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // only a full frame to a known address writes
  task automatic model_frame(input logic [7:0] addr, input logic [7:0] val, input int nbits);
    if (nbits == frame_bits)
    begin
      case (addr)
        addr_led: exp_led = val;
        addr_mux: exp_mux = val;
        addr_dac: exp_dac = val[3:0];
        default: ;
      endcase
    end
  endtask

  // lane low when master cs is active and its mux bit set
  function automatic logic [num_periph-1:0] expected_cs(input logic [7:0] mux, input logic active);
    logic [num_periph-1:0] res;
    for (int i = 0; i < num_periph; i++)
      res[i] = !(active && mux[i]);
    return res;
  endfunction

  function automatic logic expected_miso(input logic [7:0] mux,
                                         input logic [num_periph-1:0] pm);
    logic res;
    res = 1'b0;
    for (int i = 0; i < num_periph; i++)
      if (mux[i] && pm[i])
        res = 1'b1;
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // msb first, fpga addressed, data latched on falling sclk
  task automatic write_frame(input logic [7:0] addr, input logic [7:0] val, input int nbits);
    logic [16:0] data;
    data = {1'b1, addr, val};
    @(posedge clk);
    special_n <= 1'b0;
    cs_n      <= 1'b0;
    repeat (half_cyc) @(posedge clk);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi <= data[i];
      sclk <= 1'b1;
      repeat (half_cyc) @(posedge clk);
      sclk <= 1'b0;
      repeat (half_cyc) @(posedge clk);
    end
    cs_n <= 1'b1;
    // special_n stays low through the commit
    repeat (half_cyc) @(posedge clk);
    special_n <= 1'b1;
    mosi      <= 1'b0;
    model_frame(addr, val, nbits);
  endtask

  task automatic check_regs;
    int n;
    n = 0;
    @(negedge clk);
    while ((led !== exp_led || dac_ctrl !== exp_dac) && n < wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (led !== exp_led || dac_ctrl !== exp_dac)
    begin
      $display("timeout waiting for led and dac_ctrl to reach the model values");
      timeout_cnt++;
    end
    // values must hold afterwards
    repeat (4)
    begin
      compare_value("led", 32'(led), 32'(exp_led));
      compare_value("dac_ctrl", 32'(dac_ctrl), 32'(exp_dac));
      @(negedge clk);
    end
  endtask

  // normal traffic with random miso patterns, mux seen through routing
  task automatic check_routing(input int patterns);
    logic [num_periph-1:0] pm;
    int n;
    @(posedge clk);
    cs_n <= 1'b0;
    n = 0;
    @(negedge clk);
    while (periph_cs_n !== expected_cs(exp_mux, 1'b1) && n < wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (periph_cs_n !== expected_cs(exp_mux, 1'b1))
    begin
      $display("timeout waiting for periph_cs_n to follow the mux register");
      timeout_cnt++;
    end
    for (int k = 0; k < patterns; k++)
    begin
      pm = num_periph'($urandom);
      @(posedge clk);
      periph_miso <= pm;
      @(negedge clk);
      compare_value("miso", 32'(miso), 32'(expected_miso(exp_mux, pm)));
    end
    @(posedge clk);
    cs_n <= 1'b1;
    @(negedge clk);
    compare_value("periph_cs_n", 32'(periph_cs_n), 32'(expected_cs(exp_mux, 1'b0)));
  endtask

  task automatic watch_heartbeat(input int changes);
    logic [1:0] last;
    int n;
    int seen;
    @(negedge clk);
    last = hb_led;
    seen = 0;
    while (seen < changes)
    begin
      n = 0;
      while (hb_led === last && n < hb_limit)
      begin
        @(negedge clk);
        n++;
      end
      if (hb_led === last)
      begin
        $display("timeout: heartbeat leds stopped changing");
        timeout_cnt++;
        seen = changes;
      end
      else
      begin
        last = hb_led;
        seen++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [7:0]  val;
    logic [7:0]  addr;
    int unsigned assert_cnt;
    void'($urandom(91942));
    rst_n        = 1'b0;
    sclk         = 1'b0;
    cs_n         = 1'b1;
    mosi         = 1'b0;
    special_n    = 1'b1;
    periph_miso  = '0;
    exp_led      = '0;
    exp_mux      = '0;
    exp_dac      = '0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // reset state
    @(negedge clk);
    compare_value("led", 32'(led), 32'(0));
    compare_value("dac_ctrl", 32'(dac_ctrl), 32'(0));
    compare_value("periph_cs_n", 32'(periph_cs_n), 32'({num_periph{1'b1}}));
    compare_value("miso", 32'(miso), 32'(0));
    compare_value("hb_led", 32'(hb_led), 32'(0));
    check_routing(4);

    // full frames, known and unknown addresses
    for (int r = 0; r < 6; r++)
    begin
      write_frame(addr_led, 8'($urandom), frame_bits);
      check_regs();
      write_frame(addr_dac, 8'($urandom), frame_bits);
      check_regs();
      write_frame(addr_mux, 8'($urandom), frame_bits);
      check_regs();
      check_routing(6);
      addr = 8'($urandom);
      if (addr >= addr_led && addr <= addr_dac)
        addr = addr ^ 8'h80;
      write_frame(addr, 8'($urandom), frame_bits);
      check_regs();
      check_routing(2);
    end

    // short and long frames are dropped
    for (int r = 0; r < 3; r++)
    begin
      val = 8'($urandom);
      write_frame(addr_led, val, frame_bits - 1);
      check_regs();
      write_frame(addr_dac, val, frame_bits + 1);
      check_regs();
      write_frame(addr_mux, val, frame_bits + 1);
      check_regs();
      write_frame(addr_mux, val, frame_bits - 1);
      check_regs();
      check_routing(2);
    end

    // heartbeat, more than one full gray cycle
    watch_heartbeat(30);

    assert_cnt = DUT.u_props.fail_count;
    $display("mismatches %0d, timeouts %0d, assertion failures %0d",
             mismatch_cnt, timeout_cnt, assert_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && assert_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== testbench/spi_fabric_properties.sv ====
`timescale 1ns/1ps

module spi_fabric_properties
  import spi_fabric_pkg::*;
#(
  parameter int num_periph = 3
)
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  sclk,
  input logic                  cs_n,
  input logic                  mosi,
  input logic                  special_n,
  input ctrl_regs_t            regs,
  input logic                  periph_sclk,
  input logic                  periph_mosi,
  input logic [num_periph-1:0] periph_cs_n,
  input logic [num_periph-1:0] periph_miso,
  input logic                  miso,
  input logic [1:0]            hb_led
);

  // running total of failed properties
  int unsigned fail_count = 0;

  // mux bits that have a peripheral behind them
  logic [num_periph-1:0] sel;

  assign sel = regs.mux[num_periph-1:0];

  //////////////////////////////////////////////////////////////////////
  // routing
  //////////////////////////////////////////////////////////////////////

  // clock and data reach every peripheral unchanged
  a_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
    (periph_sclk == sclk) && (periph_mosi == mosi))
  else
  begin
    $error("periph_sclk or periph_mosi does not match the master line");
    fail_count++;
  end

  // idle master leaves every lane deselected
  a_cs_follow: assert property (@(posedge clk) disable iff (!rst_n)
    special_n |-> (periph_cs_n == (cs_n ? '1 : ~sel)))
  else
  begin
    $error("periph_cs_n does not follow cs_n through the mux");
    fail_count++;
  end

  // all peripherals off the bus while the fpga is addressed
  a_cs_special: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> (&periph_cs_n))
  else
  begin
    $error("a peripheral was selected while special_n was low");
    fail_count++;
  end

  // selected lanes or'ed together
  a_miso_merge: assert property (@(posedge clk) disable iff (!rst_n)
    miso == (|(periph_miso & sel)))
  else
  begin
    $error("miso is not the or of the selected periph_miso lines");
    fail_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // reset state and heartbeat
  //////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (regs == '0) && (&periph_cs_n) && !miso && (hb_led == 2'b00))
  else
  begin
    $error("outputs not in their reset state when reset was released");
    fail_count++;
  end

  // at most one led flips per clk
  a_gray_step: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(hb_led ^ $past(hb_led)) <= 1)
  else
  begin
    $error("both heartbeat leds changed on the same step");
    fail_count++;
  end

endmodule

bind spi_fabric_top spi_fabric_properties #(
  .num_periph (num_periph)
) u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .sclk        (sclk),
  .cs_n        (cs_n),
  .mosi        (mosi),
  .special_n   (special_n),
  .regs        (regs),
  .periph_sclk (periph_sclk),
  .periph_mosi (periph_mosi),
  .periph_cs_n (periph_cs_n),
  .periph_miso (periph_miso),
  .miso        (miso),
  .hb_led      (hb_led)
);

// ==== hdl/spi_fabric_top.sv ====
`timescale 1ns/1ps

module spi_fabric_top
  import spi_fabric_pkg::*;
#(
  parameter int num_periph = 3,
  parameter int log2_delay = 20
)
(
  input  logic                  clk,
  input  logic                  rst_n,

  // master spi
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  input  logic                  special_n,
  output logic                  miso,

  // shared peripheral lines
  output logic                  periph_sclk,
  output logic                  periph_mosi,

  // per peripheral, adc at bit 0, dac at 1, flash at 2
  output logic [num_periph-1:0] periph_cs_n,
  input  logic [num_periph-1:0] periph_miso,

  // board outputs
  output logic [7:0]            led,
  output logic [3:0]            dac_ctrl,
  output logic [1:0]            hb_led
);

  //////////////////////////////////////////////////////////////////////
  // master bus bundle
  //////////////////////////////////////////////////////////////////////

  spi_bus_t   bus;
  ctrl_regs_t regs;

  assign bus = '{sclk: sclk, cs_n: cs_n, special_n: special_n, mosi: mosi};

  // clock and data go straight to every peripheral
  // only cs decides who listens
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  spi_reg_bank u_reg_bank (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .regs  (regs)
  );

  assign led      = regs.led;
  // ldac, rst, uni_bip_a, uni_bip_b from bit 0
  assign dac_ctrl = regs.dac;

  //////////////////////////////////////////////////////////////////////
  // routing
  //////////////////////////////////////////////////////////////////////

  cs_router #(
    .num_periph (num_periph)
  ) u_cs_router (
    .bus         (bus),
    .mux         (regs.mux),
    .periph_cs_n (periph_cs_n)
  );

  miso_router #(
    .num_periph (num_periph)
  ) u_miso_router (
    .mux         (regs.mux),
    .periph_miso (periph_miso),
    .miso        (miso)
  );

  //////////////////////////////////////////////////////////////////////
  // heartbeat
  //////////////////////////////////////////////////////////////////////

  // slow blink, shows the clock is alive
  heartbeat #(
    .log2_delay (log2_delay)
  ) u_heartbeat (
    .clk    (clk),
    .rst_n  (rst_n),
    .hb_led (hb_led)
  );

endmodule

// ==== hdl/heartbeat.sv ====
`timescale 1ns/1ps

module heartbeat #(
  parameter int log2_delay = 20
)
(
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] hb_led
);

  // width of the slow count
  localparam int bits = 5;

  //////////////////////////////////////////////////////////////////////
  // free running counter
  //////////////////////////////////////////////////////////////////////

  logic [bits+log2_delay-1:0] count;
  // registered top bits
  logic [bits-1:0]            out_cnt;
  logic [bits-1:0]            gray;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count   <= '0;
      out_cnt <= '0;
    end
    else
    begin
      count   <= count + 1'b1;
      // divide by 2**log2_delay
      out_cnt <= count[bits+log2_delay-1 -: bits];
    end
  end

  // binary to gray
  // one bit flips per step
  assign gray = out_cnt ^ (out_cnt >> 1);

  // two low gray bits onto the leds
  assign hb_led = gray[1:0];

endmodule

// ==== hdl/miso_router.sv ====
`timescale 1ns/1ps

module miso_router #(
  parameter int num_periph = 3
)
(
  input  logic [7:0]            mux,
  input  logic [num_periph-1:0] periph_miso,
  output logic                  miso
);

  //////////////////////////////////////////////////////////////////////
  // miso merge
  //////////////////////////////////////////////////////////////////////

  // unselected peripherals masked to zero
  logic [num_periph-1:0] masked;

  assign masked = periph_miso & mux[num_periph-1:0];

  // wired-or of whatever is left
  // several selected lanes just combine
  // special_n plays no part here
  assign miso = |masked;

endmodule

// ==== hdl/cs_router.sv ====
`timescale 1ns/1ps

module cs_router
  import spi_fabric_pkg::*;
#(
  parameter int num_periph = 3
)
(
  input  spi_bus_t              bus,
  input  logic [7:0]            mux,
  output logic [num_periph-1:0] periph_cs_n
);

  //////////////////////////////////////////////////////////////////////
  // chip select routing
  //////////////////////////////////////////////////////////////////////

  // only the low num_periph mux bits have a peripheral behind them
  logic [num_periph-1:0] sel;
  // master cs, active high, copied to every lane
  logic [num_periph-1:0] cs_vec;

  assign sel    = mux[num_periph-1:0];
  assign cs_vec = {num_periph{~bus.cs_n}};

  // pure gates, no flops
  // keeps the master's cs timing intact
  always_comb
  begin
    if (bus.special_n)
    begin
      // normal traffic
      // selected peripherals follow master cs
      periph_cs_n = ~(sel & cs_vec);
    end
    else
    begin
      // fpga is being addressed
      // hold everyone off the bus
      periph_cs_n = '1;
    end
  end

endmodule

// ==== hdl/spi_reg_bank.sv ====
`timescale 1ns/1ps

module spi_reg_bank
  import spi_fabric_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  spi_bus_t   bus,
  output ctrl_regs_t regs
);

  // counter has to hold frame_bits + 1 to see an overlong frame
  localparam int cnt_w = $clog2(frame_bits + 2);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(frame_bits + 1);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(frame_bits);

  // lines at rest, cs and special deasserted
  localparam spi_bus_t bus_idle = '{sclk: 1'b0, cs_n: 1'b1, special_n: 1'b1, mosi: 1'b0};

  //////////////////////////////////////////////////////////////////////
  // input synchronizers
  //////////////////////////////////////////////////////////////////////

  // two flop stages per line
  spi_bus_t sync_1;
  spi_bus_t sync_2;

  // previous values for edge detect
  logic sclk_d;
  logic cs_n_d;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sync_1 <= bus_idle;
      sync_2 <= bus_idle;
      sclk_d <= bus_idle.sclk;
      cs_n_d <= bus_idle.cs_n;
    end
    else
    begin
      sync_1 <= bus;
      sync_2 <= sync_1;
      sclk_d <= sync_2.sclk;
      cs_n_d <= sync_2.cs_n;
    end
  end

  // shift on falling sclk
  logic sclk_fall;
  // end of frame
  logic cs_rise;
  // frame is addressed to the fpga and in progress
  logic in_frame;

  assign sclk_fall = sclk_d & ~sync_2.sclk;
  assign cs_rise   = ~cs_n_d & sync_2.cs_n;
  assign in_frame  = ~sync_2.cs_n & ~sync_2.special_n;

  //////////////////////////////////////////////////////////////////////
  // shift register and bit count
  //////////////////////////////////////////////////////////////////////

  logic [frame_bits-1:0] shift_q;
  logic [cnt_w-1:0]      bit_cnt;

  // msb first
  always_ff @(posedge clk)
  begin
    if (in_frame && sclk_fall)
      shift_q <= {shift_q[frame_bits-2:0], sync_2.mosi};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    // idle bus, start over
    else if (sync_2.cs_n)
      bit_cnt <= '0;
    // stick at 17 so long frames never wrap back to 16
    else if (in_frame && sclk_fall && bit_cnt != cnt_max)
      bit_cnt <= bit_cnt + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // decode and commit
  //////////////////////////////////////////////////////////////////////

  logic [7:0] frame_addr;
  logic [7:0] frame_val;
  logic       commit;

  assign frame_addr = shift_q[frame_bits-1 -: 8];
  assign frame_val  = shift_q[7:0];

  // count still holds this frame's total on the cs edge
  assign commit = cs_rise & ~sync_2.special_n & (bit_cnt == cnt_full);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      regs <= '0;
    end
    else if (commit)
    begin
      case (frame_addr)
        addr_mux: regs.mux <= frame_val;
        addr_led: regs.led <= frame_val;
        // low nibble only
        addr_dac: regs.dac <= frame_val[3:0];
        // unknown address, nothing written
        default: regs <= regs;
      endcase
    end
  end

endmodule

// ==== hdl/spi_fabric_pkg.sv ====
package spi_fabric_pkg;

  //////////////////////////////////////////////////////////////////////
  // master side spi lines
  //////////////////////////////////////////////////////////////////////

  // straight from the mcu pins, not yet synchronized
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    // low when the frame is meant for the fpga
    logic special_n;
  } spi_bus_t;

  //////////////////////////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // one bit per peripheral, set to route cs and miso
    logic [7:0] mux;
    // board leds
    logic [7:0] led;
    // bit 0 ldac, bit 1 rst, bit 2 uni_bip_a, bit 3 uni_bip_b
    logic [3:0] dac;
  } ctrl_regs_t;

  // address byte then value byte
  localparam int frame_bits = 16;

  // register map
  localparam logic [7:0] addr_led = 8'd7;
  localparam logic [7:0] addr_mux = 8'd8;
  localparam logic [7:0] addr_dac = 8'd9;

endpackage
